/* design/cache_pkg.sv */
// geometry is fixed here (32-bit words, 64-byte lines, 8 lines); nothing is parameterized per module
package cache_pkg;

  localparam int ADDR_W         = 32;
  localparam int OFF_W          = 6;  // 64-byte lines
  localparam int INDEX_W        = 3;
  localparam int TAG_W          = ADDR_W - INDEX_W - OFF_W;
  localparam int NUM_LINES      = 8;
  localparam int WORDS_PER_LINE = 16;
  localparam int WORD_IDX_W     = 4;
  localparam int BURST_W        = 5;  // must hold WORDS_PER_LINE

  typedef logic [31:0] data_t;

  // overlays one byte address
  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [OFF_W-1:0]   offset;
  } addr_fields_t;

  // answer of one line to one read port
  typedef struct packed {
    data_t            data;   // word at the requested offset
    logic             valid;
    logic             dirty;
    logic             hit;    // valid and tag equal
    logic [TAG_W-1:0] tag;
  } line_rd_t;

  // one word written into a line, with the new line state
  typedef struct packed {
    logic [WORD_IDX_W-1:0] word;
    logic [TAG_W-1:0]      tag;
    logic                  valid;
    logic                  dirty;
    data_t                 data;
  } line_wr_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITEBACK,
    ST_REFILL
  } fill_state_e;

endpackage

/* design/cache_line.sv */
// one cache line; only tag state is reset, so data words are meaningful only while valid is set
module cache_line
  import cache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  addr_fields_t          rd_a_i,
  input  addr_fields_t          rd_b_i,
  output line_rd_t              rd_a_o,
  output line_rd_t              rd_b_o,
  input  logic                  we_i,
  input  line_wr_t              wr_i,
  input  logic [WORD_IDX_W-1:0] lkup_word_i,
  output data_t                 lkup_data_o
);

  logic [TAG_W-1:0] tag_q;
  logic             valid_q;
  logic             dirty_q;
  data_t            words_q [WORDS_PER_LINE];

  // hit check and word select for one read port
  function automatic line_rd_t line_read(input addr_fields_t addr);
    line_rd_t res;
    res.data  = words_q[addr.offset[OFF_W-1:2]];
    res.valid = valid_q;
    res.dirty = dirty_q;
    res.hit   = valid_q && (tag_q == addr.tag);
    res.tag   = tag_q;
    return res;
  endfunction

  always_comb begin
    rd_a_o = line_read(rd_a_i);
  end

  always_comb begin
    rd_b_o = line_read(rd_b_i);
  end

  assign lkup_data_o = words_q[lkup_word_i];  // victim word for writeback

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_q   <= '0;
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (we_i) begin
      tag_q   <= wr_i.tag;
      valid_q <= wr_i.valid;  // refill keeps it low until the last word
      dirty_q <= wr_i.dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      words_q[wr_i.word] <= wr_i.data;
    end
  end

  // dirty writes come only from port A hits, never from a refill in progress
  a_dirty_on_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    (we_i && wr_i.dirty) |-> (valid_q && wr_i.valid)
  );

endmodule

/* design/line_fill_ctrl.sv */
// miss handler; port A wins over port B, one line in flight, burstcount fixed to a whole line
module line_fill_ctrl
  import cache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  miss_a_i,
  input  logic                  miss_b_i,
  input  addr_fields_t          addr_a_i,
  input  addr_fields_t          addr_b_i,
  input  logic                  victim_dirty_i,
  input  logic [TAG_W-1:0]      victim_tag_i,
  output logic                  fill_active_o,
  output logic [INDEX_W-1:0]    fill_index_o,
  output logic                  fill_we_o,
  output line_wr_t              fill_wr_o,
  output logic [WORD_IDX_W-1:0] lkup_word_o,
  input  data_t                 lkup_data_i,
  output logic [ADDR_W-1:0]     m_address_o,
  output logic [BURST_W-1:0]    m_burstcount_o,
  output logic                  m_read_o,
  output logic                  m_write_o,
  output data_t                 m_writedata_o,
  input  data_t                 m_readdata_i,
  input  logic                  m_waitrequest_i,
  input  logic                  m_readdatavalid_i
);

  fill_state_e           state_q;
  addr_fields_t          miss_sel;
  addr_fields_t          miss_q;
  logic [WORD_IDX_W-1:0] word_q;
  logic                  last_word;

  assign miss_sel  = miss_a_i ? addr_a_i : addr_b_i;  // port A first
  assign last_word = (word_q == WORD_IDX_W'(WORDS_PER_LINE - 1));

  assign fill_active_o = (state_q != ST_IDLE);
  // in idle the index follows the pending miss so the victim can be inspected
  assign fill_index_o  = fill_active_o ? miss_q.index : miss_sel.index;

  assign m_burstcount_o = BURST_W'(WORDS_PER_LINE);
  assign lkup_word_o    = word_q;
  assign m_writedata_o  = lkup_data_i;  // victim word at the beat counter

  // refill words go in clean; the line turns valid with the last one
  assign fill_we_o = (state_q == ST_REFILL) && m_readdatavalid_i;

  always_comb begin
    fill_wr_o.word  = word_q;
    fill_wr_o.tag   = miss_q.tag;
    fill_wr_o.valid = last_word;
    fill_wr_o.dirty = 1'b0;
    fill_wr_o.data  = m_readdata_i;
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE) begin
      miss_q <= miss_sel;  // held for the whole fill
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ST_IDLE;
      word_q      <= '0;
      m_address_o <= '0;
      m_read_o    <= 1'b0;
      m_write_o   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          word_q <= '0;
          if (miss_a_i || miss_b_i) begin
            if (victim_dirty_i) begin
              state_q     <= ST_WRITEBACK;
              m_address_o <= {victim_tag_i, miss_sel.index, {OFF_W{1'b0}}};
              m_write_o   <= 1'b1;
            end else begin
              state_q     <= ST_REFILL;
              m_address_o <= {miss_sel.tag, miss_sel.index, {OFF_W{1'b0}}};
              m_read_o    <= 1'b1;
            end
          end
        end

        ST_WRITEBACK: begin
          if (!m_waitrequest_i) begin
            word_q <= word_q + 1'b1;  // wraps to 0 for the refill
            if (last_word) begin
              state_q     <= ST_REFILL;
              m_write_o   <= 1'b0;
              m_read_o    <= 1'b1;
              m_address_o <= {miss_q.tag, miss_q.index, {OFF_W{1'b0}}};
            end
          end
        end

        ST_REFILL: begin
          if (m_read_o && !m_waitrequest_i) begin
            m_read_o <= 1'b0;  // command accepted
          end
          if (m_readdatavalid_i) begin
            word_q <= word_q + 1'b1;
            if (last_word) begin
              state_q <= ST_IDLE;
            end
          end
        end

        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  a_no_rd_wr: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(m_read_o && m_write_o)
  );

  // a stalled write beat must be presented again unchanged
  a_beat_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    (m_write_o && m_waitrequest_i) |=> ($stable(word_q) && $stable(m_writedata_o))
  );

endmodule

/* design/cache_top.sv */
// cache top; requesters hold their request while waitrequest is high, no byte enables
module cache_top
  import cache_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  // port A, reads and writes
  input  logic [ADDR_W-1:0]  a_address_i,
  input  logic               a_read_i,
  input  logic               a_write_i,
  input  data_t              a_writedata_i,
  output data_t              a_readdata_o,
  output logic               a_waitrequest_o,
  // port B, reads only
  input  logic [ADDR_W-1:0]  b_address_i,
  input  logic               b_read_i,
  output data_t              b_readdata_o,
  output logic               b_waitrequest_o,
  // burst master to memory
  output logic [ADDR_W-1:0]  m_address_o,
  output logic [BURST_W-1:0] m_burstcount_o,
  output logic               m_read_o,
  output logic               m_write_o,
  output data_t              m_writedata_o,
  input  data_t              m_readdata_i,
  input  logic               m_waitrequest_i,
  input  logic               m_readdatavalid_i
);

  addr_fields_t          a_fields;
  addr_fields_t          b_fields;
  line_rd_t              rd_a [NUM_LINES];
  line_rd_t              rd_b [NUM_LINES];
  data_t                 lkup_data [NUM_LINES];
  logic [NUM_LINES-1:0]  line_we;
  line_rd_t              sel_a;
  line_rd_t              sel_b;
  logic                  miss_a;
  logic                  miss_b;
  logic                  direct_we;
  line_wr_t              direct_wr;
  line_wr_t              fill_wr;
  line_wr_t              line_wr;
  logic                  fill_active;
  logic                  fill_we;
  logic [INDEX_W-1:0]    fill_index;
  logic [WORD_IDX_W-1:0] lkup_word;
  logic                  victim_dirty;
  logic [TAG_W-1:0]      victim_tag;

  assign a_fields = addr_fields_t'(a_address_i);
  assign b_fields = addr_fields_t'(b_address_i);

  assign sel_a = rd_a[a_fields.index];
  assign sel_b = rd_b[b_fields.index];

  assign a_readdata_o = sel_a.data;
  assign b_readdata_o = sel_b.data;

  assign miss_a = (a_read_i || a_write_i) && !sel_a.hit;
  assign miss_b = b_read_i && !sel_b.hit;

  // a write hit also waits out a fill since the line array has one write port
  assign a_waitrequest_o = (a_read_i && !sel_a.hit) ||
                           (a_write_i && (!sel_a.hit || fill_active));
  assign b_waitrequest_o = miss_b;

  assign direct_we = a_write_i && sel_a.hit && !fill_active;

  always_comb begin
    direct_wr.word  = a_fields.offset[OFF_W-1:2];
    direct_wr.tag   = a_fields.tag;
    direct_wr.valid = 1'b1;
    direct_wr.dirty = 1'b1;
    direct_wr.data  = a_writedata_i;
  end

  assign line_wr = fill_active ? fill_wr : direct_wr;

  // victim state is read through port A's view, which ignores the request tag
  assign victim_dirty = rd_a[fill_index].dirty ||
                        (direct_we && (a_fields.index == fill_index));  // same-edge write hit
  assign victim_tag   = rd_a[fill_index].tag;

  for (genvar g = 0; g < NUM_LINES; g++) begin : g_line
    assign line_we[g] = fill_active ? (fill_we && (fill_index == INDEX_W'(g)))
                                    : (direct_we && (a_fields.index == INDEX_W'(g)));

    cache_line u_line (
      .clk         (clk),
      .rst_n       (rst_n),
      .rd_a_i      (a_fields),
      .rd_b_i      (b_fields),
      .rd_a_o      (rd_a[g]),
      .rd_b_o      (rd_b[g]),
      .we_i        (line_we[g]),
      .wr_i        (line_wr),
      .lkup_word_i (lkup_word),
      .lkup_data_o (lkup_data[g])
    );
  end

  line_fill_ctrl u_fill (
    .clk               (clk),
    .rst_n             (rst_n),
    .miss_a_i          (miss_a),
    .miss_b_i          (miss_b),
    .addr_a_i          (a_fields),
    .addr_b_i          (b_fields),
    .victim_dirty_i    (victim_dirty),
    .victim_tag_i      (victim_tag),
    .fill_active_o     (fill_active),
    .fill_index_o      (fill_index),
    .fill_we_o         (fill_we),
    .fill_wr_o         (fill_wr),
    .lkup_word_o       (lkup_word),
    .lkup_data_i       (lkup_data[fill_index]),
    .m_address_o       (m_address_o),
    .m_burstcount_o    (m_burstcount_o),
    .m_read_o          (m_read_o),
    .m_write_o         (m_write_o),
    .m_writedata_o     (m_writedata_o),
    .m_readdata_i      (m_readdata_i),
    .m_waitrequest_i   (m_waitrequest_i),
    .m_readdatavalid_i (m_readdatavalid_i)
  );

endmodule

/* bench/burst_mem_model.sv */
// Avalon burst memory for simulation; covers byte addresses below 4 KB only, one burst at a time
module burst_mem_model
  import cache_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [ADDR_W-1:0]  address_i,
  input  logic [BURST_W-1:0] burstcount_i,
  input  logic               read_i,
  input  logic               write_i,
  input  data_t              writedata_i,
  output data_t              readdata_o,
  output logic               waitrequest_o,
  output logic               readdatavalid_o,
  output int unsigned        rd_bursts_o,
  output int unsigned        wr_bursts_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 1024;

  data_t              mem [MEM_WORDS];
  logic [1:0]         cmd_cnt;
  logic [9:0]         word_base;
  logic [9:0]         wr_idx;
  logic [9:0]         rd_ptr;
  logic [BURST_W-1:0] rd_left;
  logic               rd_wait;
  logic [BURST_W-1:0] wr_beat;

  assign word_base     = address_i[11:2];
  assign wr_idx        = word_base + 10'(wr_beat);
  assign waitrequest_o = (cmd_cnt == 2'd2);  // every third command cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_cnt <= '0;
    end else if (read_i || write_i) begin
      cmd_cnt <= (cmd_cnt == 2'd2) ? 2'd0 : cmd_cnt + 1'b1;
    end
  end

  // reset reloads the fill pattern
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= data_t'(i * 4) ^ 32'hA5A5_0000;  // byte address xor pattern
      end
      wr_beat     <= '0;
      wr_bursts_o <= 0;
    end else if (write_i && !waitrequest_o) begin
      mem[wr_idx] <= writedata_i;
      if (wr_beat == burstcount_i - 1'b1) begin
        wr_beat     <= '0;
        wr_bursts_o <= wr_bursts_o + 1;
      end else begin
        wr_beat <= wr_beat + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr          <= '0;
      rd_left         <= '0;
      rd_wait         <= 1'b0;
      readdata_o      <= '0;
      readdatavalid_o <= 1'b0;
      rd_bursts_o     <= 0;
    end else begin
      readdatavalid_o <= 1'b0;
      if (rd_left != '0) begin
        if (rd_wait) begin
          rd_wait <= 1'b0;  // second latency cycle
        end else begin
          readdatavalid_o <= 1'b1;
          readdata_o      <= mem[rd_ptr];
          rd_ptr          <= rd_ptr + 1'b1;
          rd_left         <= rd_left - 1'b1;
        end
      end else if (read_i && !waitrequest_o) begin
        rd_ptr      <= word_base;
        rd_left     <= burstcount_i;
        rd_wait     <= 1'b1;
        rd_bursts_o <= rd_bursts_o + 1;
      end
    end
  end

endmodule

/* bench/cache_top_tb.sv */
// directed tests for cache_top; test addresses stay below 4 KB, the size of the memory model
module cache_top_tb
  import cache_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAND_OPS  = 60;
  localparam int TOTAL_OPS = 12 + RAND_OPS + NUM_LINES;  // directed + random + final eviction
  localparam int MEM_WORDS = 1024;

  logic               clk = 1'b0;
  logic               rst_n;
  logic [ADDR_W-1:0]  a_address;
  logic               a_read;
  logic               a_write;
  data_t              a_writedata;
  data_t              a_readdata;
  logic               a_waitrequest;
  logic [ADDR_W-1:0]  b_address;
  logic               b_read;
  data_t              b_readdata;
  logic               b_waitrequest;
  logic [ADDR_W-1:0]  m_address;
  logic [BURST_W-1:0] m_burstcount;
  logic               m_read;
  logic               m_write;
  data_t              m_writedata;
  data_t              m_readdata;
  logic               m_waitrequest;
  logic               m_readdatavalid;
  int unsigned        rd_bursts;
  int unsigned        wr_bursts;
  data_t              ref_mem [MEM_WORDS];  // expected memory as seen through the cache
  int                 errors;
  int                 checks;
  int                 tests;

  cache_top uut (
    .clk (clk), .rst_n (rst_n),
    .a_address_i (a_address), .a_read_i (a_read), .a_write_i (a_write),
    .a_writedata_i (a_writedata), .a_readdata_o (a_readdata),
    .a_waitrequest_o (a_waitrequest),
    .b_address_i (b_address), .b_read_i (b_read), .b_readdata_o (b_readdata),
    .b_waitrequest_o (b_waitrequest),
    .m_address_o (m_address), .m_burstcount_o (m_burstcount), .m_read_o (m_read),
    .m_write_o (m_write), .m_writedata_o (m_writedata), .m_readdata_i (m_readdata),
    .m_waitrequest_i (m_waitrequest), .m_readdatavalid_i (m_readdatavalid)
  );

  burst_mem_model u_mem (
    .clk (clk), .rst_n (rst_n),
    .address_i (m_address), .burstcount_i (m_burstcount), .read_i (m_read),
    .write_i (m_write), .writedata_i (m_writedata), .readdata_o (m_readdata),
    .waitrequest_o (m_waitrequest), .readdatavalid_o (m_readdatavalid),
    .rd_bursts_o (rd_bursts), .wr_bursts_o (wr_bursts)
  );

  always #4 clk = ~clk;

  function automatic logic [ADDR_W-1:0] make_addr(input int unsigned tag,
                                                  input int unsigned index,
                                                  input int unsigned word);
    addr_fields_t f;
    f.tag    = TAG_W'(tag);
    f.index  = INDEX_W'(index);
    f.offset = OFF_W'(word * 4);
    return f;
  endfunction

  function automatic logic [9:0] word_addr(input logic [ADDR_W-1:0] addr);
    return addr[11:2];
  endfunction

  // initial memory content is the byte address xor A5A5_0000
  function automatic data_t pattern(input logic [9:0] widx);
    return {20'b0, widx, 2'b00} ^ 32'hA5A5_0000;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int unsigned got, input int unsigned exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic read_a(input logic [ADDR_W-1:0] addr, output data_t data);
    @(posedge clk);
    a_address <= addr;
    a_read    <= 1'b1;
    @(negedge clk);
    while (a_waitrequest) begin
      @(negedge clk);
    end
    data = a_readdata;
    @(posedge clk);
    a_read <= 1'b0;
  endtask

  task automatic read_b(input logic [ADDR_W-1:0] addr, output data_t data);
    @(posedge clk);
    b_address <= addr;
    b_read    <= 1'b1;
    @(negedge clk);
    while (b_waitrequest) begin
      @(negedge clk);
    end
    data = b_readdata;
    @(posedge clk);
    b_read <= 1'b0;
  endtask

  task automatic write_a(input logic [ADDR_W-1:0] addr, input data_t data);
    @(posedge clk);
    a_address   <= addr;
    a_writedata <= data;
    a_write     <= 1'b1;
    @(negedge clk);
    while (a_waitrequest) begin
      @(negedge clk);
    end
    @(posedge clk);
    a_write <= 1'b0;  // word stored at this edge
    ref_mem[word_addr(addr)] = data;
  endtask

  task automatic cold_read_miss();
    int          e0;
    int unsigned rb0;
    data_t       d;
    logic [ADDR_W-1:0] addr;
    e0   = errors;
    rb0  = rd_bursts;
    addr = make_addr(0, 0, 5);
    read_a(addr, d);
    check_data("a_readdata", d, ref_mem[word_addr(addr)]);
    check_count("read bursts", rd_bursts, rb0 + 1);
    report_test("cold read miss", e0);
  endtask

  task automatic port_b_hit();
    int          e0;
    int unsigned rb0;
    data_t       d;
    logic [ADDR_W-1:0] addr;
    e0  = errors;
    rb0 = rd_bursts;
    for (int w = 0; w < WORDS_PER_LINE; w += 7) begin
      addr = make_addr(0, 0, w);
      read_b(addr, d);
      check_data("b_readdata", d, ref_mem[word_addr(addr)]);
    end
    check_count("read bursts", rd_bursts, rb0);
    report_test("hit on port B", e0);
  endtask

  task automatic write_hit_readback();
    int          e0;
    int unsigned wb0;
    data_t       d;
    logic [ADDR_W-1:0] addr;
    e0   = errors;
    wb0  = wr_bursts;
    addr = make_addr(0, 0, 9);
    write_a(addr, 32'h1234_5678);
    read_a(addr, d);
    check_data("a_readdata", d, 32'h1234_5678);
    read_b(addr, d);
    check_data("b_readdata", d, 32'h1234_5678);
    check_count("write bursts", wr_bursts, wb0);
    check_data("memory word", u_mem.mem[word_addr(addr)], pattern(word_addr(addr)));
    report_test("write hit and read-back", e0);
  endtask

  task automatic dirty_eviction();
    int          e0;
    int unsigned wb0;
    data_t       d;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] old;
    e0   = errors;
    wb0  = wr_bursts;
    addr = make_addr(1, 0, 2);
    old  = make_addr(0, 0, 9);
    read_a(addr, d);
    check_count("write bursts", wr_bursts, wb0 + 1);
    check_data("memory word", u_mem.mem[word_addr(old)], ref_mem[word_addr(old)]);
    check_data("a_readdata", d, ref_mem[word_addr(addr)]);
    report_test("dirty eviction", e0);
  endtask

  task automatic write_miss_alloc();
    int          e0;
    int unsigned rb0;
    int unsigned wb0;
    data_t       d;
    logic [ADDR_W-1:0] addr;
    e0   = errors;
    rb0  = rd_bursts;
    wb0  = wr_bursts;
    addr = make_addr(2, 3, 7);
    write_a(addr, 32'hCAFE_F00D);
    check_count("read bursts", rd_bursts, rb0 + 1);
    check_count("write bursts", wr_bursts, wb0);
    read_a(addr, d);
    check_data("a_readdata", d, 32'hCAFE_F00D);
    read_b(make_addr(2, 3, 0), d);
    check_data("b_readdata", d, ref_mem[word_addr(make_addr(2, 3, 0))]);
    read_b(make_addr(2, 3, 15), d);
    check_data("b_readdata", d, ref_mem[word_addr(make_addr(2, 3, 15))]);
    report_test("write miss", e0);
  endtask

  task automatic random_traffic();
    int          e0;
    int unsigned kind;
    data_t       d;
    logic [ADDR_W-1:0] addr;
    e0 = errors;
    for (int i = 0; i < RAND_OPS; i++) begin
      addr = make_addr($urandom_range(0, 3), $urandom_range(0, NUM_LINES - 1),
                       $urandom_range(0, WORDS_PER_LINE - 1));
      kind = $urandom_range(0, 2);
      case (kind)
        0: begin
          read_a(addr, d);
          check_data("a_readdata", d, ref_mem[word_addr(addr)]);
        end
        1: begin
          read_b(addr, d);
          check_data("b_readdata", d, ref_mem[word_addr(addr)]);
        end
        default: begin
          write_a(addr, $urandom);
        end
      endcase
    end
    // tag 6 is never used above, so every line gets evicted
    for (int i = 0; i < NUM_LINES; i++) begin
      read_a(make_addr(6, i, 0), d);
      check_data("a_readdata", d, ref_mem[word_addr(make_addr(6, i, 0))]);
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_data($sformatf("memory word %0d", i), u_mem.mem[i], ref_mem[i]);
    end
    report_test("random traffic", e0);
  endtask

  initial begin
    void'($urandom(75));
    rst_n       <= 1'b0;
    a_address   <= '0;
    a_read      <= 1'b0;
    a_write     <= 1'b0;
    a_writedata <= '0;
    b_address   <= '0;
    b_read      <= 1'b0;
    errors = 0;
    checks = 0;
    tests  = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = pattern(10'(i));
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    cold_read_miss();
    port_b_hit();
    write_hit_readback();
    dirty_eviction();
    write_miss_alloc();
    random_traffic();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    repeat (TOTAL_OPS * 200) @(posedge clk);
    $display("Timeout after %0d cycles, an operation never completed", TOTAL_OPS * 200);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* cache_top.f */
design/cache_pkg.sv
design/cache_line.sv
design/line_fill_ctrl.sv
design/cache_top.sv
bench/burst_mem_model.sv
bench/cache_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds cache_top_tb with Verilator, runs it and checks the log.
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module cache_top_tb \
  -f cache_top.f \
  -o cache_top_sim

./obj_dir/cache_top_sim | tee "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "simulation finished, log in $LOG"
